// ==== design/dmem_wb_pkg.sv ====
// Bridge widths, command/width/response enums and request structs
package dmem_wb_pkg;

   //------------------------------------------------------------------------
   // Widths
   //------------------------------------------------------------------------
   localparam int unsigned DMEM_AW = 32;              // Core and bus address
   localparam int unsigned DMEM_DW = 32;              // Data bus
   localparam int unsigned DMEM_SW = DMEM_DW / 8;     // Byte selects

   //------------------------------------------------------------------------
   // Core side encodings
   //------------------------------------------------------------------------
   typedef enum logic {
      DMEM_CMD_RD = 1'b0,                             // Load
      DMEM_CMD_WR = 1'b1                              // Store
   } dmem_cmd_e;

   typedef enum logic [1:0] {
      DMEM_WIDTH_BYTE  = 2'b00,
      DMEM_WIDTH_HWORD = 2'b01,
      DMEM_WIDTH_WORD  = 2'b10
   } dmem_width_e;

   // Same code points as the core memory response
   typedef enum logic [1:0] {
      DMEM_RESP_IDLE = 2'b00,                         // No response this cycle
      DMEM_RESP_RDY  = 2'b01,                         // Done, data valid on read
      DMEM_RESP_ERR  = 2'b10                          // Slave raised err
   } dmem_resp_e;

   //------------------------------------------------------------------------
   // Request payloads
   //------------------------------------------------------------------------
   typedef struct packed {
      dmem_cmd_e            cmd;                      // Read or write
      dmem_width_e          width;                    // Access size
      logic [DMEM_AW-1:0]   addr;                     // Byte address
      logic [DMEM_DW-1:0]   wdata;                    // Right-justified store data
   } dmem_core_req_t;

   typedef struct packed {
      logic [DMEM_AW-1:0]   adr;                      // Word-aligned address
      logic                 we;                       // Write enable
      logic [DMEM_DW-1:0]   dat;                      // Lane-aligned write data
      logic [DMEM_SW-1:0]   sel;                      // Byte lanes
   } wb_req_t;

endpackage : dmem_wb_pkg

// ==== design/dmem_req_capture.sv ====
// Core request acceptance, byte-select and lane alignment into bus requests
module dmem_req_capture (
   input  logic                        core_clk_i,      // Core clock
   input  logic                        rst_n_i,         // Sync reset, active low
   input  logic                        core_req_vld_i,  // Request valid
   input  dmem_wb_pkg::dmem_core_req_t core_req_i,      // Request payload
   input  logic                        fifo_full_i,     // No free slot
   output logic                        core_req_ack_o,  // Request taken
   output logic                        push_o,          // Write strobe to FIFO
   output dmem_wb_pkg::wb_req_t        push_req_o       // Formatted bus request
);
   import dmem_wb_pkg::*;

   logic [1:0]         byte_ofs;                        // Offset inside the word
   logic [DMEM_SW-1:0] sel;
   logic [DMEM_DW-1:0] lane_dat;

   assign byte_ofs = core_req_i.addr[1:0];

   //------------------------------------------------------------------------
   // Byte select and write lane replication
   //------------------------------------------------------------------------
   always_comb begin
      case (core_req_i.width)
         DMEM_WIDTH_BYTE: begin
            sel      = DMEM_SW'(1) << byte_ofs;         // One lane at offset
            lane_dat = {4{core_req_i.wdata[7:0]}};
         end
         DMEM_WIDTH_HWORD: begin
            sel      = byte_ofs[1] ? 4'b1100 : 4'b0011; // Upper or lower half
            lane_dat = {2{core_req_i.wdata[15:0]}};
         end
         default: begin
            sel      = 4'b1111;                         // Full word
            lane_dat = core_req_i.wdata;
         end
      endcase
   end

   assign push_req_o.adr = {core_req_i.addr[DMEM_AW-1:2], 2'b00}; // Word aligned
   assign push_req_o.we  = (core_req_i.cmd == DMEM_CMD_WR);
   assign push_req_o.dat = lane_dat;
   assign push_req_o.sel = sel;

   // Ack straight from the FIFO flag, push in the same cycle
   assign core_req_ack_o = ~fifo_full_i;
   assign push_o         = core_req_vld_i & core_req_ack_o;

   // Misaligned halfword or word is not supported by the bridge
   a_aligned : assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      push_o |-> ((core_req_i.width != DMEM_WIDTH_HWORD) || !byte_ofs[0]) &&
                 ((core_req_i.width != DMEM_WIDTH_WORD)  || (byte_ofs == 2'b00)))
      else $error("misaligned core access at 0x%08h", core_req_i.addr);

endmodule : dmem_req_capture

// ==== design/dmem_req_fifo.sv ====
// Circular register FIFO of formatted bus requests with occupancy count
module dmem_req_fifo #(
   parameter int unsigned DEPTH = 4                     // Queue slots
) (
   input  logic                 core_clk_i,             // Core clock
   input  logic                 rst_n_i,                // Sync reset, active low
   input  logic                 push_i,                 // Write strobe
   input  dmem_wb_pkg::wb_req_t push_req_i,             // Entry to queue
   input  logic                 pop_i,                  // Drop the head
   output logic                 full_o,                 // No free slot
   output logic                 not_empty_o,            // Head is valid
   output dmem_wb_pkg::wb_req_t head_req_o              // Oldest entry
);
   import dmem_wb_pkg::*;

   localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CW = $clog2(DEPTH + 1);

   wb_req_t         mem_q [DEPTH];                      // Entry storage
   logic [PW-1:0]   wr_ptr_q;
   logic [PW-1:0]   rd_ptr_q;
   logic [CW-1:0]   count_q;
   logic [CW-1:0]   count_d;
   logic            full_q;

   // Pointer advance with wrap, DEPTH need not be a power of two
   function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
      if (ptr == PW'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign count_d = count_q + CW'(push_i) - CW'(pop_i);

   //------------------------------------------------------------------------
   // Pointers, count and full flag
   //------------------------------------------------------------------------
   always_ff @(posedge core_clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         full_q   <= 1'b1;                              // No ack while in reset
      end else begin
         if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
         count_q <= count_d;
         full_q  <= (count_d == CW'(DEPTH));
      end
   end

   always_ff @(posedge core_clk_i) begin
      if (push_i) mem_q[wr_ptr_q] <= push_req_i;       // Visible at head next cycle
   end

   assign full_o      = full_q;
   assign not_empty_o = (count_q != '0);
   assign head_req_o  = mem_q[rd_ptr_q];

   // Producer must respect full, consumer must respect empty
   a_no_overflow : assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      push_i |-> !full_o) else $error("push into full request FIFO");
   a_no_underflow : assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      pop_i |-> not_empty_o) else $error("pop from empty request FIFO");

endmodule : dmem_req_fifo

// ==== design/dmem_wb_master.sv ====
// Wishbone classic master FSM, read data alignment and core response
module dmem_wb_master (
   input  logic                           core_clk_i,    // Core clock
   input  logic                           rst_n_i,       // Sync reset, active low
   input  logic                           not_empty_i,   // FIFO holds a request
   input  dmem_wb_pkg::wb_req_t           head_req_i,    // Oldest request
   input  logic [dmem_wb_pkg::DMEM_DW-1:0] wbd_dat_i,    // Read data
   input  logic                           wbd_ack_i,     // Transfer done
   input  logic                           wbd_err_i,     // Transfer failed
   output logic                           pop_o,         // Release FIFO head
   output logic                           wbd_cyc_o,     // Cycle
   output logic                           wbd_stb_o,     // Strobe
   output logic [dmem_wb_pkg::DMEM_AW-1:0] wbd_adr_o,    // Address
   output logic                           wbd_we_o,      // Write
   output logic [dmem_wb_pkg::DMEM_DW-1:0] wbd_dat_o,    // Write data
   output logic [dmem_wb_pkg::DMEM_SW-1:0] wbd_sel_o,    // Byte enable
   output logic [dmem_wb_pkg::DMEM_DW-1:0] core_rdata_o, // Load data to core
   output dmem_wb_pkg::dmem_resp_e        core_resp_o    // One pulse per request
);
   import dmem_wb_pkg::*;

   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_BUSY = 1'b1
   } state_e;

   state_e             state_q;
   logic               bus_done;                         // Ack or err this cycle
   logic [DMEM_DW-1:0] rd_align;
   logic [DMEM_DW-1:0] rdata_q;
   dmem_resp_e         resp_q;

   assign bus_done = (state_q == ST_BUSY) & (wbd_ack_i | wbd_err_i);
   assign pop_o    = bus_done;

   //------------------------------------------------------------------------
   // Bus drive, head stays put until the pop
   //------------------------------------------------------------------------
   assign wbd_cyc_o = (state_q == ST_BUSY);
   assign wbd_stb_o = wbd_cyc_o;                        // Single transfer per cycle
   assign wbd_we_o  = wbd_cyc_o & head_req_i.we;
   assign wbd_adr_o = head_req_i.adr;
   assign wbd_dat_o = head_req_i.dat;
   assign wbd_sel_o = head_req_i.sel;

   // Shift lowest selected lane down, zero the rest
   always_comb begin
      case (head_req_i.sel)
         4'b0001: rd_align = {24'h0, wbd_dat_i[7:0]};
         4'b0010: rd_align = {24'h0, wbd_dat_i[15:8]};
         4'b0100: rd_align = {24'h0, wbd_dat_i[23:16]};
         4'b1000: rd_align = {24'h0, wbd_dat_i[31:24]};
         4'b0011: rd_align = {16'h0, wbd_dat_i[15:0]};
         4'b1100: rd_align = {16'h0, wbd_dat_i[31:16]};
         default: rd_align = wbd_dat_i;                 // Full word
      endcase
   end

   //------------------------------------------------------------------------
   // FSM and response pulse
   //------------------------------------------------------------------------
   always_ff @(posedge core_clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         resp_q  <= DMEM_RESP_IDLE;
      end else begin
         resp_q <= DMEM_RESP_IDLE;                      // Pulse lasts one cycle
         case (state_q)
            ST_IDLE: if (not_empty_i) state_q <= ST_BUSY;
            ST_BUSY: begin
               if (bus_done) begin
                  state_q <= ST_IDLE;                   // cyc/stb drop next cycle
                  resp_q  <= wbd_err_i ? DMEM_RESP_ERR : DMEM_RESP_RDY;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge core_clk_i) begin
      if (bus_done && !head_req_i.we) rdata_q <= rd_align; // Load data only
   end

   assign core_rdata_o = rdata_q;
   assign core_resp_o  = resp_q;

   // Classic cycle holds cyc, stb and request until the slave answers
   a_hold_cycle : assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      (wbd_cyc_o && !(wbd_ack_i || wbd_err_i)) |=>
         (wbd_cyc_o && wbd_stb_o && $stable(wbd_adr_o) && $stable(wbd_we_o) &&
          $stable(wbd_dat_o) && $stable(wbd_sel_o)))
      else $error("wishbone cycle changed before ack or err");

endmodule : dmem_wb_master

// ==== design/dmem_wb_bridge.sv ====
// Data memory to Wishbone bridge top with capture, request FIFO and master
module dmem_wb_bridge #(
   parameter int unsigned REQ_DEPTH = 4                  // Queued requests
) (
   input  logic                           core_clk_i,    // Core and bus clock
   input  logic                           rst_n_i,       // Sync reset, active low
   // Core data memory port
   input  logic                           core_req_vld_i,
   input  dmem_wb_pkg::dmem_core_req_t    core_req_i,
   output logic                           core_req_ack_o,
   output logic [dmem_wb_pkg::DMEM_DW-1:0] core_rdata_o,
   output dmem_wb_pkg::dmem_resp_e        core_resp_o,
   // Wishbone classic master
   output logic                           wbd_cyc_o,
   output logic                           wbd_stb_o,
   output logic [dmem_wb_pkg::DMEM_AW-1:0] wbd_adr_o,
   output logic                           wbd_we_o,
   output logic [dmem_wb_pkg::DMEM_DW-1:0] wbd_dat_o,
   output logic [dmem_wb_pkg::DMEM_SW-1:0] wbd_sel_o,
   input  logic [dmem_wb_pkg::DMEM_DW-1:0] wbd_dat_i,
   input  logic                           wbd_ack_i,
   input  logic                           wbd_err_i
);
   import dmem_wb_pkg::*;

   logic    push;                                       // Capture to FIFO
   wb_req_t push_req;
   logic    fifo_full;
   logic    fifo_not_empty;                             // FIFO to master
   wb_req_t head_req;
   logic    pop;

   //------------------------------------------------------------------------
   // Producer, buffer, consumer
   //------------------------------------------------------------------------
   dmem_req_capture u_capture (
      .core_clk_i     (core_clk_i    ),
      .rst_n_i        (rst_n_i       ),
      .core_req_vld_i (core_req_vld_i),
      .core_req_i     (core_req_i    ),
      .fifo_full_i    (fifo_full     ),
      .core_req_ack_o (core_req_ack_o),
      .push_o         (push          ),
      .push_req_o     (push_req      )
   );

   dmem_req_fifo #(
      .DEPTH          (REQ_DEPTH     )
   ) u_req_fifo (
      .core_clk_i     (core_clk_i    ),
      .rst_n_i        (rst_n_i       ),
      .push_i         (push          ),
      .push_req_i     (push_req      ),
      .pop_i          (pop           ),
      .full_o         (fifo_full     ),
      .not_empty_o    (fifo_not_empty),
      .head_req_o     (head_req      )
   );

   dmem_wb_master u_wb_master (
      .core_clk_i     (core_clk_i    ),
      .rst_n_i        (rst_n_i       ),
      .not_empty_i    (fifo_not_empty),
      .head_req_i     (head_req      ),
      .wbd_dat_i      (wbd_dat_i     ),
      .wbd_ack_i      (wbd_ack_i     ),
      .wbd_err_i      (wbd_err_i     ),
      .pop_o          (pop           ),
      .wbd_cyc_o      (wbd_cyc_o     ),
      .wbd_stb_o      (wbd_stb_o     ),
      .wbd_adr_o      (wbd_adr_o     ),
      .wbd_we_o       (wbd_we_o      ),
      .wbd_dat_o      (wbd_dat_o     ),
      .wbd_sel_o      (wbd_sel_o     ),
      .core_rdata_o   (core_rdata_o  ),
      .core_resp_o    (core_resp_o   )
   );

endmodule : dmem_wb_bridge

// ==== tb/wb_slave_model.sv ====
// Wishbone classic slave with 16-word memory, random wait states and an error region
module wb_slave_model #(
   parameter int SEED = 1                               // Wait-state seed
) (
   input  logic        clk_i,
   input  logic        rst_n_i,                         // Sync reset, active low
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic [31:0] adr_i,
   input  logic        we_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o
);
   localparam int WORDS = 16;

   logic [31:0] mem [WORDS];
   logic [1:0]  wait_cnt;                               // Wait states left
   logic        armed;                                  // Wait count drawn for this cycle
   logic        in_range;
   int          seed;
   int          rnd;

   initial seed = SEED;

   assign in_range = (adr_i[31:6] == '0);               // Word 16 and up answers err

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_o    <= 1'b0;
         err_o    <= 1'b0;
         armed    <= 1'b0;
         wait_cnt <= '0;
         dat_o    <= '0;
         for (int i = 0; i < WORDS; i++) mem[i] <= '0;
      end else begin
         ack_o <= 1'b0;                                 // One-cycle answer
         err_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o && !err_o) begin
            if (!armed) begin
               rnd = $random(seed);
               wait_cnt <= rnd[1:0];                    // 0 to 3 extra cycles
               armed    <= 1'b1;
            end else if (wait_cnt != 0) begin
               wait_cnt <= wait_cnt - 1'b1;
            end else begin
               armed <= 1'b0;
               if (!in_range) begin
                  err_o <= 1'b1;                        // No write on err
               end else begin
                  ack_o <= 1'b1;
                  dat_o <= mem[adr_i[5:2]];
                  for (int b = 0; b < 4; b++) begin
                     if (we_i && sel_i[b]) mem[adr_i[5:2]][8*b +: 8] <= dat_i[8*b +: 8];
                  end
               end
            end
         end
      end
   end

endmodule : wb_slave_model

// ==== tb/dmem_wb_tb.sv ====
// Bridge testbench top with clock, reset, golden-vector driver, response checks and timeout
module dmem_wb_tb;
   import dmem_wb_pkg::*;

   localparam string GOLDEN_FILE = "tb/dmem_golden.txt";
   localparam int    SEED        = 67598;               // Slave wait-state seed
   localparam int    MAX_VEC     = 64;
   localparam int    NF          = 6;                   // Fields per golden line

   logic               clk = 1'b0;
   logic               rst_n;
   logic               req_vld;
   dmem_core_req_t     req;
   logic               req_ack;
   logic [DMEM_DW-1:0] rdata;
   dmem_resp_e         resp;
   logic               wb_cyc;
   logic               wb_stb;
   logic [DMEM_AW-1:0] wb_adr;
   logic               wb_we;
   logic [DMEM_DW-1:0] wb_dat_w;
   logic [DMEM_SW-1:0] wb_sel;
   logic [DMEM_DW-1:0] wb_dat_r;
   logic               wb_ack;
   logic               wb_err;

   logic [31:0] gold [NF*MAX_VEC];                      // cmd width addr wdata rdata resp
   int          exp_q [$];                              // Vector indices in issue order
   int          n_vec = 0;
   int          n_resp = 0;
   int          n_pass = 0;
   int          n_fail = 0;
   int          reset_errs = 0;
   int          stall_cycles = 0;                       // Cycles a request waited for ack
   int          cycles = 0;
   int          limit = 0;                              // Timeout in cycles

   always #4 clk = ~clk;                                // Period 8

   dmem_wb_bridge #(.REQ_DEPTH(4)) dut (
      .core_clk_i (clk), .rst_n_i (rst_n),
      .core_req_vld_i (req_vld), .core_req_i (req), .core_req_ack_o (req_ack),
      .core_rdata_o (rdata), .core_resp_o (resp),
      .wbd_cyc_o (wb_cyc), .wbd_stb_o (wb_stb), .wbd_adr_o (wb_adr), .wbd_we_o (wb_we),
      .wbd_dat_o (wb_dat_w), .wbd_sel_o (wb_sel),
      .wbd_dat_i (wb_dat_r), .wbd_ack_i (wb_ack), .wbd_err_i (wb_err)
   );

   wb_slave_model #(.SEED(SEED)) u_slave (
      .clk_i (clk), .rst_n_i (rst_n), .cyc_i (wb_cyc), .stb_i (wb_stb),
      .adr_i (wb_adr), .we_i (wb_we), .dat_i (wb_dat_w), .sel_i (wb_sel),
      .dat_o (wb_dat_r), .ack_o (wb_ack), .err_o (wb_err)
   );

   // Bus idle and no response while reset holds the bridge
   task automatic check_idle();
      assert (!wb_cyc && !wb_stb && !wb_we && resp == DMEM_RESP_IDLE) else begin
         reset_errs++;
         $display("[ERROR] reset: expected cyc/stb/we 000 resp 0, actual %b%b%b resp %0d",
                  wb_cyc, wb_stb, wb_we, resp);
      end
   endtask

   // Drive one golden request and hold it until the bridge takes it
   task automatic issue_request(input int idx);
      @(posedge clk);
      #1;
      req_vld   = 1'b1;
      req.cmd   = dmem_cmd_e'(gold[NF*idx][0]);
      req.width = dmem_width_e'(gold[NF*idx+1][1:0]);
      req.addr  = gold[NF*idx+2];
      req.wdata = gold[NF*idx+3];
      exp_q.push_back(idx);
      while (!req_ack) begin                            // Taken at the edge after ack high
         stall_cycles++;
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_response();
      int          idx;
      int          errs;
      logic [31:0] exp_rdata;
      logic [1:0]  exp_resp;
      errs = 0;
      assert (exp_q.size() > 0) else begin
         n_fail++;
         $display("response seen with no request outstanding");
      end
      if (exp_q.size() > 0) begin
         idx       = exp_q.pop_front();
         exp_rdata = gold[NF*idx+4];
         exp_resp  = gold[NF*idx+5][1:0];
         assert (resp == exp_resp) else begin
            errs++;
            $display("[ERROR] vec%0d resp: expected %0d actual %0d", idx, exp_resp, resp);
         end
         if (gold[NF*idx][0] == 1'b0 && exp_resp == DMEM_RESP_RDY) begin  // Ready loads only
            assert (rdata == exp_rdata) else begin
               errs++;
               $display("[ERROR] vec%0d rdata: expected %08h actual %08h",
                        idx, exp_rdata, rdata);
            end
         end
         n_resp++;
         if (errs == 0) begin
            n_pass++;
            $display("vec%0d: pass", idx);
         end else begin
            n_fail++;
            $display("vec%0d: fail", idx);
         end
      end
   endtask

   // Response pulse sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n && resp != DMEM_RESP_IDLE) check_response();
   end

   always @(posedge clk) begin
      if (rst_n) begin
         cycles = cycles + 1;
         if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d of %0d responses missing",
                     cycles, n_vec - n_resp, n_vec);
            $display("CHECKS FAILED");
            $finish;
         end
      end
   end

   initial begin
      rst_n   = 1'b0;
      req_vld = 1'b0;
      req     = '0;
      foreach (gold[i]) gold[i] = '1;                   // All ones marks end of table
      $readmemh(GOLDEN_FILE, gold);
      while (n_vec < MAX_VEC && gold[NF*n_vec] != '1) n_vec++;
      limit = n_vec * 8 + 100;
      repeat (10) begin
         @(posedge clk);
         #1 check_idle();
         assert (!req_ack) else begin                   // No request taken in reset
            reset_errs++;
            $display("[ERROR] reset: expected core_req_ack_o 0, actual %b", req_ack);
         end
      end
      rst_n = 1'b1;
      @(posedge clk);
      #1 check_idle();
      if (reset_errs == 0) begin
         n_pass++;
         $display("reset: pass");
      end else begin
         n_fail++;
         $display("reset: fail");
      end
      for (int i = 0; i < n_vec; i++) issue_request(i);
      @(posedge clk);
      #1 req_vld = 1'b0;                                // Last request taken at that edge
      wait (n_resp == n_vec);
      @(posedge clk);
      assert (stall_cycles > 0) else begin
         n_fail++;
         $display("back-pressure: fail, core_req_ack_o never went low with requests queued");
      end
      if (stall_cycles > 0) begin
         n_pass++;
         $display("back-pressure: pass, %0d stall cycles", stall_cycles);
      end
      $display("tests: %0d passed, %0d failed, %0d vectors", n_pass, n_fail, n_vec);
      if (n_fail == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule : dmem_wb_tb

// ==== tb/dmem_golden.txt ====
// cmd(0 rd,1 wr) width(0 b,1 h,2 w) addr wdata exp_rdata exp_resp(1 rdy,2 err)
// Write data is right-justified, rdata is checked on ready reads only
1 2 00000000 DEADBEEF 00000000 1
0 2 00000000 00000000 DEADBEEF 1
1 0 00000004 00000011 00000000 1
1 0 00000005 00000022 00000000 1
1 0 00000006 00000033 00000000 1
1 0 00000007 00000044 00000000 1
0 2 00000004 00000000 44332211 1
0 1 00000006 00000000 00004433 1
0 0 00000005 00000000 00000022 1
1 2 00000040 12345678 00000000 2
0 2 00000080 00000000 00000000 2
0 2 00000000 00000000 DEADBEEF 1
1 2 00000008 01234567 00000000 1
1 1 0000000C 0000BEEF 00000000 1
1 1 0000000E 0000CAFE 00000000 1
0 2 0000000C 00000000 CAFEBEEF 1
0 0 0000000B 00000000 00000001 1
0 1 00000008 00000000 00004567 1
1 2 0000003C A5A55A5A 00000000 1
0 2 0000003C 00000000 A5A55A5A 1

// ==== sources.f ====
design/dmem_wb_pkg.sv
design/dmem_req_capture.sv
design/dmem_req_fifo.sv
design/dmem_wb_master.sv
design/dmem_wb_bridge.sv
tb/wb_slave_model.sv
tb/dmem_wb_tb.sv

// ==== Bender.yml ====
package:
  name: dmem_wb_bridge

sources:
  - design/dmem_wb_pkg.sv
  - design/dmem_req_capture.sv
  - design/dmem_req_fifo.sv
  - design/dmem_wb_master.sv
  - design/dmem_wb_bridge.sv
  - target: simulation
    files:
      - tb/wb_slave_model.sv
      - tb/dmem_wb_tb.sv
